// ==== source/div_defs.svh ====
//----------------------------------------
// divider width and step count macros
// data width, steps per operation size,
// step counter width
//----------------------------------------
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// data path width of the core
`define DIV_XLEN    64

// restoring steps per operation
`define DIV_STEPS_D 64  // 64-bit forms
`define DIV_STEPS_W 32  // word forms

// must hold DIV_STEPS_D
`define DIV_CNT_W   7

`endif

// ==== source/div_pkg.sv ====
//----------------------------------------
// divider shared types
// data word, operation flags, request,
// prepared operands, control states
//----------------------------------------
`include "div_defs.svh"

package div_pkg;

  // one register-file data word
  typedef logic [`DIV_XLEN-1:0] div_word_t;

  // decoded M-extension division operation
  typedef struct packed {
    logic is_rem;       // remainder instead of quotient
    logic is_unsigned;  // unsigned operands
    logic is_word;      // 32-bit word form
  } div_op_t;

  // request as presented by the core
  typedef struct packed {
    div_op_t   op;
    div_word_t dividend;
    div_word_t divisor;
  } div_req_t;

  // operation after sign stripping and special case check
  typedef struct packed {
    div_op_t   op;
    div_word_t dividend_mag;    // word forms sit in the upper half
    div_word_t divisor_mag;
    logic      neg_q;           // negate the quotient at the end
    logic      neg_r;           // negate the remainder at the end
    logic      special;         // zero divisor or signed overflow
    div_word_t special_result;
  } div_prep_t;

  // control FSM
  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    FINISH
  } div_state_e;

endpackage

// ==== source/div_ctrl.sv ====
//----------------------------------------
// divider control
// IDLE/DIVIDE/FINISH FSM, step counter,
// request and response handshakes
//----------------------------------------
`timescale 1ns/1ps
`include "div_defs.svh"

module div_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_i,
  input  logic ready_i,
  input  logic special_i,
  input  logic is_word_i,
  output logic ready_o,
  output logic done_o,
  output logic load_o,
  output logic step_o
);

  div_pkg::div_state_e   state_q;
  div_pkg::div_state_e   state_d;
  logic [`DIV_CNT_W-1:0] cnt_q;
  logic [`DIV_CNT_W-1:0] cnt_d;
  logic                  accept;

  assign ready_o = (state_q == div_pkg::IDLE);
  assign accept  = valid_i & ready_o;

  assign load_o = accept;
  assign step_o = (state_q == div_pkg::DIVIDE);
  assign done_o = (state_q == div_pkg::FINISH);

  //----------------------------------------
  // next state
  //----------------------------------------
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      div_pkg::IDLE: begin
        if (accept) begin
          if (special_i) begin
            state_d = div_pkg::FINISH;  // no iterations needed
          end else begin
            state_d = div_pkg::DIVIDE;
            cnt_d   = is_word_i ? `DIV_CNT_W'(`DIV_STEPS_W) : `DIV_CNT_W'(`DIV_STEPS_D);
          end
        end
      end
      div_pkg::DIVIDE: begin
        cnt_d = cnt_q - 1'b1;
        if (cnt_q == `DIV_CNT_W'(1)) begin  // last step this cycle
          state_d = div_pkg::FINISH;
        end
      end
      div_pkg::FINISH: begin
        if (ready_i) begin
          state_d = div_pkg::IDLE;
        end
      end
      default: begin
        state_d = div_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= div_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

// ==== source/div_operand_prep.sv ====
//----------------------------------------
// divider operand preparation
// word extension, magnitudes, sign flags,
// zero divisor and overflow detection
//----------------------------------------
`timescale 1ns/1ps

module div_operand_prep (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               load_i,
  input  div_pkg::div_req_t  req_i,
  output logic               special_o,
  output div_pkg::div_prep_t prep_o
);

  div_pkg::div_op_t   op;
  div_pkg::div_word_t a_sext32;
  div_pkg::div_word_t b_sext32;
  div_pkg::div_word_t a_ext;
  div_pkg::div_word_t b_ext;
  div_pkg::div_word_t a_mag;
  div_pkg::div_word_t b_mag;
  div_pkg::div_word_t spec_res;
  logic               a_neg;
  logic               b_neg;
  logic               zero_div;
  logic               ovf;
  div_pkg::div_prep_t prep_d;

  assign op = req_i.op;

  assign a_sext32 = {{32{req_i.dividend[31]}}, req_i.dividend[31:0]};
  assign b_sext32 = {{32{req_i.divisor[31]}}, req_i.divisor[31:0]};

  //----------------------------------------
  // operand extension and magnitudes
  //----------------------------------------
  always_comb begin
    if (!op.is_word) begin
      a_ext = req_i.dividend;
      b_ext = req_i.divisor;
    end else if (op.is_unsigned) begin
      a_ext = {32'b0, req_i.dividend[31:0]};  // divuw and remuw zero extend
      b_ext = {32'b0, req_i.divisor[31:0]};
    end else begin
      a_ext = a_sext32;
      b_ext = b_sext32;
    end
  end

  assign a_neg = !op.is_unsigned && a_ext[63];
  assign b_neg = !op.is_unsigned && b_ext[63];
  assign a_mag = a_neg ? -a_ext : a_ext;
  assign b_mag = b_neg ? -b_ext : b_ext;

  //----------------------------------------
  // special cases, resolved without steps
  //----------------------------------------
  assign zero_div = op.is_word ? (req_i.divisor[31:0] == 32'b0)
                               : (req_i.divisor == 64'b0);

  // most negative over minus one
  assign ovf = !op.is_unsigned && !zero_div &&
               (op.is_word ? (req_i.dividend[31:0] == 32'h8000_0000 && &req_i.divisor[31:0])
                           : (req_i.dividend == {1'b1, 63'b0} && &req_i.divisor));

  always_comb begin
    spec_res = '0;
    if (zero_div) begin
      if (op.is_rem) begin
        spec_res = op.is_word ? a_sext32 : req_i.dividend;
      end else begin
        spec_res = '1;
      end
    end else if (ovf && !op.is_rem) begin
      spec_res = op.is_word ? {{32{1'b1}}, 32'h8000_0000} : {1'b1, 63'b0};
    end
  end

  assign special_o = zero_div | ovf;

  always_comb begin
    prep_d.op             = op;
    prep_d.dividend_mag   = op.is_word ? {a_mag[31:0], 32'b0} : a_mag;
    prep_d.divisor_mag    = b_mag;
    prep_d.neg_q          = a_neg ^ b_neg;
    prep_d.neg_r          = a_neg;                // remainder follows the dividend
    prep_d.special        = special_o;
    prep_d.special_result = spec_res;
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      prep_o <= '0;
    end else if (load_i) begin
      prep_o <= prep_d;
    end
  end

endmodule

// ==== source/div_iter.sv ====
//----------------------------------------
// restoring divider iteration
// remainder:quotient register, one
// shift-subtract step per cycle
//----------------------------------------
`timescale 1ns/1ps
`include "div_defs.svh"

module div_iter (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               load_i,
  input  logic               step_i,
  input  div_pkg::div_prep_t prep_i,
  output div_pkg::div_word_t quot_o,
  output div_pkg::div_word_t rem_o
);

  logic [2*`DIV_XLEN-1:0] rq_q;     // {remainder, quotient}
  logic [2*`DIV_XLEN-1:0] src;
  logic [`DIV_XLEN:0]     partial;  // shifted remainder, one bit wider
  logic [`DIV_XLEN+1:0]   diff;
  logic                   fresh_q;
  logic                   borrow;

  // prepared operands land on the accept edge,
  // so the first step takes the dividend straight from prep_i
  assign src = fresh_q ? {{`DIV_XLEN{1'b0}}, prep_i.dividend_mag} : rq_q;

  assign partial = src[2*`DIV_XLEN-1:`DIV_XLEN-1];
  assign diff    = {1'b0, partial} - {2'b0, prep_i.divisor_mag};
  assign borrow  = diff[`DIV_XLEN+1];

  always_ff @(posedge clk) begin
    if (rst_n) begin
      rq_q    <= '0;
      fresh_q <= 1'b0;
    end else if (load_i) begin
      rq_q    <= '0;    // remainder half starts at zero
      fresh_q <= 1'b1;
    end else if (step_i) begin
      fresh_q <= 1'b0;
      if (borrow) begin
        rq_q <= {src[2*`DIV_XLEN-2:0], 1'b0};  // restore, quotient bit 0
      end else begin
        rq_q <= {diff[`DIV_XLEN-1:0], src[`DIV_XLEN-2:0], 1'b1};
      end
    end
  end

  assign quot_o = rq_q[`DIV_XLEN-1:0];
  assign rem_o  = rq_q[2*`DIV_XLEN-1:`DIV_XLEN];

endmodule

// ==== source/div_result_fix.sv ====
//----------------------------------------
// divider result correction
// quotient or remainder select, sign
// restore, word extension, special value
//----------------------------------------
`timescale 1ns/1ps

module div_result_fix (
  input  div_pkg::div_prep_t prep_i,
  input  div_pkg::div_word_t quot_i,
  input  div_pkg::div_word_t rem_i,
  output div_pkg::div_word_t result_o
);

  div_pkg::div_word_t sel;
  div_pkg::div_word_t fixed;
  div_pkg::div_word_t word_ext;
  logic               negate;

  assign sel    = prep_i.op.is_rem ? rem_i : quot_i;
  assign negate = prep_i.op.is_rem ? prep_i.neg_r : prep_i.neg_q;

  assign fixed = negate ? -sel : sel;  // back to two's complement

  // word forms, low half only, bit 31 spreads upward
  assign word_ext = {{32{fixed[31]}}, fixed[31:0]};

  always_comb begin
    if (prep_i.special) begin
      result_o = prep_i.special_result;
    end else if (prep_i.op.is_word) begin
      result_o = word_ext;
    end else begin
      result_o = fixed;
    end
  end

endmodule

// ==== source/div_top.sv ====
//----------------------------------------
// multi-cycle RISC-V M-extension divider
// control plus prep, iteration and fix
//----------------------------------------
`timescale 1ns/1ps

module div_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid_i,
  input  div_pkg::div_req_t  req_i,
  output logic               ready_o,
  output div_pkg::div_word_t result_o,
  output logic               done_o,
  input  logic               ready_i
);

  logic               special_now;
  logic               load;
  logic               step;
  div_pkg::div_prep_t prep;
  div_pkg::div_word_t quot;
  div_pkg::div_word_t rem;

  div_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_i   (valid_i),
    .ready_i   (ready_i),
    .special_i (special_now),
    .is_word_i (req_i.op.is_word),
    .ready_o   (ready_o),
    .done_o    (done_o),
    .load_o    (load),
    .step_o    (step)
  );

  div_operand_prep u_prep (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_i    (load),
    .req_i     (req_i),
    .special_o (special_now),
    .prep_o    (prep)
  );

  div_iter u_iter (
    .clk    (clk),
    .rst_n  (rst_n),
    .load_i (load),
    .step_i (step),
    .prep_i (prep),
    .quot_o (quot),
    .rem_o  (rem)
  );

  // held stable through FINISH since prep and iter only change on load/step
  div_result_fix u_fix (
    .prep_i   (prep),
    .quot_i   (quot),
    .rem_i    (rem),
    .result_o (result_o)
  );

endmodule

// ==== sim/tb_div_top.sv ====
//----------------------------------------
// testbench for the multi-cycle divider
// directed table plus seeded random rows,
// reference model, latency and hold checks
//----------------------------------------
`timescale 1ns/1ps

module tb_div_top;

  typedef struct packed {
    div_pkg::div_op_t op;
    logic [63:0]      a;
    logic [63:0]      b;
    logic [3:0]       dly;  // cycles ready_i stays low
    logic [63:0]      exp;
  } row_t;

  localparam int TIMEOUT = 200;
  localparam div_pkg::div_op_t OP_DIV   = 3'b000;  // {is_rem, is_unsigned, is_word}
  localparam div_pkg::div_op_t OP_DIVU  = 3'b010;
  localparam div_pkg::div_op_t OP_REM   = 3'b100;
  localparam div_pkg::div_op_t OP_REMU  = 3'b110;
  localparam div_pkg::div_op_t OP_DIVW  = 3'b001;
  localparam div_pkg::div_op_t OP_DIVUW = 3'b011;
  localparam div_pkg::div_op_t OP_REMW  = 3'b101;
  localparam div_pkg::div_op_t OP_REMUW = 3'b111;

  logic               clk;
  logic               rst_n;
  logic               valid_i;
  logic               ready_i;
  logic               ready_o;
  logic               done_o;
  div_pkg::div_req_t  req_i;
  div_pkg::div_word_t result_o;

  row_t   rows[$];
  integer seed;
  int     err_cnt;
  int     pass_cnt;
  int     fail_cnt;

  div_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (valid_i),
    .req_i    (req_i),
    .ready_o  (ready_o),
    .result_o (result_o),
    .done_o   (done_o),
    .ready_i  (ready_i)
  );

  always #5 clk = ~clk;

  //----------------------------------------
  // reference model from the ISA rules
  //----------------------------------------
  function automatic logic [63:0] ref_result(input div_pkg::div_op_t op,
                                             input logic [63:0] a, input logic [63:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] sa32;
    logic signed [31:0] sb32;
    logic [31:0]        r32;
    logic [63:0]        r64;
    sa = a;
    sb = b;
    sa32 = a[31:0];
    sb32 = b[31:0];
    if (op.is_word) begin
      if (b[31:0] == 32'b0) r32 = op.is_rem ? a[31:0] : 32'hFFFF_FFFF;
      else if (op.is_unsigned) r32 = op.is_rem ? a[31:0] % b[31:0] : a[31:0] / b[31:0];
      else if (a[31:0] == 32'h8000_0000 && b[31:0] == 32'hFFFF_FFFF)
        r32 = op.is_rem ? 32'b0 : 32'h8000_0000;
      else if (op.is_rem) r32 = sa32 % sb32;  // sign of dividend
      else r32 = sa32 / sb32;                 // toward zero
      r64 = {{32{r32[31]}}, r32};
    end else begin
      if (b == 64'b0) r64 = op.is_rem ? a : '1;
      else if (op.is_unsigned) r64 = op.is_rem ? a % b : a / b;
      else if (a == {1'b1, 63'b0} && b == '1) r64 = op.is_rem ? 64'b0 : a;
      else if (op.is_rem) r64 = sa % sb;
      else r64 = sa / sb;
    end
    ref_result = r64;
  endfunction

  // special cases finish right away
  // and the rest take one cycle more than their steps
  function automatic int expected_latency(input div_pkg::div_op_t op,
                                          input logic [63:0] a, input logic [63:0] b);
    logic special;
    if (op.is_word)
      special = (b[31:0] == 32'b0) ||
                (!op.is_unsigned && a[31:0] == 32'h8000_0000 && b[31:0] == 32'hFFFF_FFFF);
    else
      special = (b == 64'b0) || (!op.is_unsigned && a == {1'b1, 63'b0} && b == '1);
    expected_latency = special ? 1 : (op.is_word ? 33 : 65);
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic abort_on_timeout(input string what, input int idx);
    $display("timeout in test %0d, %s never came", idx, what);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic add_row(input div_pkg::div_op_t op, input logic [63:0] a,
                         input logic [63:0] b, input int dly, input logic [63:0] exp);
    rows.push_back(row_t'{op: op, a: a, b: b, dly: dly[3:0], exp: exp});
  endtask

  //----------------------------------------
  // one request and response from a falling edge
  //----------------------------------------
  task automatic run_test(input int idx, input row_t r);
    int          lat;
    int          cnt;
    int          errs_before;
    logic [63:0] held;
    errs_before = err_cnt;
    req_i = '{op: r.op, dividend: r.a, divisor: r.b};
    valid_i = 1'b1;
    cnt = 0;
    while (!ready_o) begin
      if (cnt == TIMEOUT) abort_on_timeout("ready_o", idx);
      @(negedge clk);
      cnt++;
    end
    @(negedge clk);  // accepted on the rising edge just passed
    valid_i = 1'b0;
    lat = 1;
    while (!done_o) begin
      check_value("ready_o", ready_o, 1'b0);  // busy
      if (lat == TIMEOUT) abort_on_timeout("done_o", idx);
      @(negedge clk);
      lat++;
    end
    check_value("latency", lat, expected_latency(r.op, r.a, r.b));
    check_value("result_o", result_o, r.exp);
    held = result_o;
    repeat (r.dly) begin
      @(negedge clk);
      check_value("done_o", done_o, 1'b1);
      check_value("result_o", result_o, held);
      check_value("ready_o", ready_o, 1'b0);
    end
    ready_i = 1'b1;
    @(negedge clk);
    ready_i = 1'b0;
    check_value("done_o", done_o, 1'b0);
    check_value("ready_o", ready_o, 1'b1);  // next request welcome
    if (err_cnt == errs_before) pass_cnt++;
    else fail_cnt++;
    $display("test %0d op %b a %h b %h result %h cycles %0d %s", idx, r.op, r.a, r.b,
             held, lat, (err_cnt == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    row_t        r;
    logic [31:0] hi;
    logic [31:0] lo;
    clk = 1'b0;
    rst_n = 1'b1;
    valid_i = 1'b0;
    ready_i = 1'b0;
    req_i = '0;
    seed = 32'h27170848;
    err_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;

    add_row(OP_DIVU, 64'd100, 64'd7, 0, 64'd14);
    add_row(OP_REMU, 64'd100, 64'd7, 0, 64'd2);
    add_row(OP_DIVU, '1, 64'd2, 0, 64'h7FFF_FFFF_FFFF_FFFF);
    add_row(OP_REMU, '1, 64'd2, 1, 64'd1);
    add_row(OP_DIV, 64'd7, 64'd2, 0, 64'd3);
    add_row(OP_DIV, -64'sd7, 64'd2, 0, -64'sd3);
    add_row(OP_DIV, 64'd7, -64'sd2, 0, -64'sd3);
    add_row(OP_DIV, -64'sd7, -64'sd2, 0, 64'd3);
    add_row(OP_REM, 64'd7, 64'd2, 0, 64'd1);
    add_row(OP_REM, -64'sd7, 64'd2, 0, -64'sd1);
    add_row(OP_REM, 64'd7, -64'sd2, 0, 64'd1);
    add_row(OP_REM, -64'sd7, -64'sd2, 0, -64'sd1);
    add_row(OP_DIVW, 64'h1234_5678_FFFF_FFF9, 64'hABCD_0000_0000_0002, 0, -64'sd3);
    add_row(OP_REMW, 64'h1234_5678_FFFF_FFF9, 64'hABCD_0000_0000_0002, 0, -64'sd1);
    add_row(OP_DIVUW, 64'h0000_0001_FFFF_FFFE, 64'd1, 0, 64'hFFFF_FFFF_FFFF_FFFE);
    add_row(OP_REMUW, '1, 64'h0000_0005_8000_0001, 0, 64'h0000_0000_7FFF_FFFE);
    add_row(OP_DIV, 64'd42, 64'd0, 0, '1);  // zero divisor
    add_row(OP_DIVU, 64'd42, 64'd0, 0, '1);
    add_row(OP_REM, -64'sd5, 64'd0, 0, -64'sd5);
    add_row(OP_REMU, 64'd42, 64'd0, 0, 64'd42);
    add_row(OP_DIVW, 64'd5, 64'hFFFF_FFFF_0000_0000, 0, '1);
    add_row(OP_REMW, 64'h8000_0000, 64'h1_0000_0000, 0, 64'hFFFF_FFFF_8000_0000);
    add_row(OP_REMUW, 64'h8000_0000, 64'd0, 2, 64'hFFFF_FFFF_8000_0000);
    add_row(OP_DIV, {1'b1, 63'b0}, '1, 0, {1'b1, 63'b0});  // signed overflow
    add_row(OP_REM, {1'b1, 63'b0}, '1, 0, 64'd0);
    add_row(OP_DIVW, 64'h8000_0000, 64'hFFFF_FFFF, 0, 64'hFFFF_FFFF_8000_0000);
    add_row(OP_REMW, 64'h8000_0000, 64'hFFFF_FFFF, 0, 64'd0);
    add_row(OP_DIVU, 64'd1000, 64'd10, 7, 64'd100);  // long back-pressure

    // random rows with the divisor sometimes narrowed so quotients get large
    repeat (40) begin
      lo = $random(seed);
      r.op = lo[2:0];
      hi = $random(seed);
      lo = $random(seed);
      r.a = {hi, lo};
      hi = $random(seed);
      lo = $random(seed);
      r.b = {hi, lo};
      hi = $random(seed);
      if (hi[1:0] == 2'd0) r.b = r.b & 64'hFF;
      else if (hi[1:0] == 2'd1) r.b = r.b & 64'hFFFF_FFFF;
      r.dly = hi[5:4];
      r.exp = ref_result(r.op, r.a, r.b);
      rows.push_back(r);
    end

    repeat (10) @(negedge clk);
    rst_n = 1'b0;
    check_value("ready_o", ready_o, 1'b1);
    check_value("done_o", done_o, 1'b0);
    foreach (rows[i]) run_test(i, rows[i]);

    $display("%0d tests, %0d ok, %0d mismatched, %0d errors",
             rows.size(), pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== div_top.f ====
+incdir+source
source/div_pkg.sv
source/div_ctrl.sv
source/div_operand_prep.sv
source/div_iter.sv
source/div_result_fix.sv
source/div_top.sv
sim/tb_div_top.sv

// ==== Bender.yml ====
package:
  name: div_top

sources:
  - include_dirs:
      - source
    files:
      - source/div_pkg.sv
      - source/div_ctrl.sv
      - source/div_operand_prep.sv
      - source/div_iter.sv
      - source/div_result_fix.sv
      - source/div_top.sv
  - target: test
    files:
      - sim/tb_div_top.sv
